// File: hw/px_bus_master.sv
// P-X system bus master
`default_nettype none
`timescale 1ns/10ps

module px_bus_master import px_bus_pkg::*; (
	input  wire         got,
	input  wire         clo_,
	input  wire         start,	// Memory cycle wanted
	input  wire         px_bus_cmd_t cmd,
	output logic        bus_req,
	output px_bus_cmd_t bus_cmd,
	input  wire         bus_ack,
	input  wire         rep_valid,	// Reply latched by REP_RX
	output logic        rep_take,
	output logic        done,	// Four-phase cycle closed
	output logic        alarm	// Sticky until reset
);

	typedef enum logic [1:0] {
		BM_IDLE = 2'd0,	// No cycle open
		BM_REQ  = 2'd1,	// req high, waiting for ack
		BM_ACK  = 2'd2,	// req dropped, waiting for ack low
		BM_DEAD = 2'd3	// Timed out
	} bm_state_t;

	bm_state_t bst;
	logic [BUS_TMO_W-1:0] tmo;	// Cycles since req rose

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			bst <= BM_IDLE;
			tmo <= '0;
			alarm <= 1'b0;
		end else begin
			case (bst)
				BM_IDLE: begin
					if (start) begin
						bst <= BM_REQ;	// Phase 1
						tmo <= '0;
					end
				end
				BM_REQ: begin
					if (bus_ack) begin
						bst <= BM_ACK;	// Phase 3, req falls
					end else if (tmo == BUS_TMO_W'(BUS_TIMEOUT - 1)) begin
						bst <= BM_DEAD;	// No answer
						alarm <= 1'b1;
					end else begin
						tmo <= tmo + 1'b1;
					end
				end
				BM_ACK: if (done) bst <= BM_IDLE;
				default: bst <= BM_DEAD;	// Only reset leaves
			endcase
		end
	end

	// Command frozen for the whole cycle
	always_ff @(posedge got) begin
		if ((bst == BM_IDLE) && start)
			bus_cmd <= cmd;
	end

	assign bus_req = (bst == BM_REQ);
	assign done = (bst == BM_ACK) && !bus_ack && rep_valid;	// Phase 4 seen
	assign rep_take = done;	// Reply read on the same cycle

endmodule

`default_nettype wire

// File: hw/px_bus_pkg.sv
// P-X system bus definitions
`default_nettype none

package px_bus_pkg;

	// Memory cycle request put on the bus
	typedef struct packed {
		logic        wr;	// 1 = write, 0 = read
		logic [15:0] addr;	// Memory address
		logic [15:0] data;	// Write data, don't care on reads
	} px_bus_cmd_t;

	// Answer from the bus, valid while ack is high
	typedef struct packed {
		logic [15:0] data;	// Read data
	} px_bus_rep_t;

	// Cycles from bus_req rising to the alarm
	localparam int BUS_TIMEOUT = 40;

	// Timeout counter width
	localparam int BUS_TMO_W = $clog2(BUS_TIMEOUT + 1);

endpackage

`default_nettype wire

// File: hw/px_hs_rx.sv
// Four-phase handshake receiver
`default_nettype none
`timescale 1ns/10ps

module px_hs_rx #(
	parameter type payload_t = logic [15:0]
) (
	input  wire      got,
	input  wire      clo_,
	input  wire      req,	// Requester side
	output logic     ack,
	input  wire      payload_t data,
	output payload_t item,	// Held payload
	output logic     item_valid,
	input  wire      take	// Consumer frees the slot
);

	logic accept;

	// New item only when the slot is empty and the last cycle has closed
	assign accept = req && !ack && !item_valid;

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			ack <= 1'b0;
			item_valid <= 1'b0;
		end else begin
			if (accept)
				ack <= 1'b1;	// Phase 2
			else if (ack && !req)
				ack <= 1'b0;	// Phase 4
			if (accept)
				item_valid <= 1'b1;
			else if (take)
				item_valid <= 1'b0;	// Slot free again
		end
	end

	always_ff @(posedge got) begin
		if (accept)
			item <= data;	// Payload is stable while req is high
	end

endmodule

`default_nettype wire

// File: hw/px_state_pkg.sv
// P-X machine state definitions
`default_nettype none

package px_state_pkg;

	// Machine states of the cut-down control unit
	typedef enum logic [3:0] {
		IDLE = 4'd0,	// Waiting for a command
		K1   = 4'd1,	// Instruction fetch
		WR   = 4'd2,	// Argument read
		WW   = 4'd3,	// Argument write
		P3   = 4'd4,	// Execute
		STOP = 4'd5	// Halted, left only by reset
	} px_state_t;

	// Instruction class, picks the state path
	typedef enum logic [1:0] {
		OP_REG   = 2'd0,	// K1, P3
		OP_READ  = 2'd1,	// K1, WR, P3
		OP_WRITE = 2'd2,	// K1, WW, P3
		OP_HALT  = 2'd3	// K1, STOP
	} px_op_t;

	// Command handed over by the instruction decoder
	typedef struct packed {
		px_op_t      op;	// Instruction class
		logic [15:0] pc;	// Fetch address
		logic [15:0] arg;	// Argument address
	} px_cmd_t;

	// Strobe phase lengths in got cycles
	localparam int STROB1_SHORT = 3;	// WR, WW
	localparam int STROB1_LONG  = 6;	// K1, P3
	localparam int STROB2_TICKS = 2;	// All active states

	// Phase counter width, covers the longest phase
	localparam int STROB_CNT_W = $clog2(STROB1_LONG + 1);

endpackage

`default_nettype wire

// File: hw/px_state_seq.sv
// P-X state sequencer
`default_nettype none
`timescale 1ns/10ps

module px_state_seq import px_state_pkg::*, px_bus_pkg::*; (
	input  wire         got,
	input  wire         clo_,
	input  wire         px_cmd_t cmd,	// Held by the command receiver
	input  wire         cmd_valid,
	output logic        cmd_take,	// Frees the receiver at the end
	input  wire         advance,	// From the strobe timer
	input  wire         bus_done,
	input  wire  [15:0] rd_data,
	input  wire         alarm,
	output logic        bus_start,	// Level, high until bus_done
	output px_bus_cmd_t bus_cmd,
	output px_state_t   state,
	output logic        hlt
);

	px_state_t state_nx;
	px_bus_cmd_t bus_cmd_nx;
	logic enter_bus;	// Next state opens a memory cycle
	logic [15:0] dreg;	// Internal data register

	// Fixed path per instruction class
	always_comb begin
		state_nx = state;
		case (state)
			IDLE: if (cmd_valid) state_nx = K1;
			K1: begin
				if (advance) begin
					case (cmd.op)
						OP_REG: state_nx = P3;
						OP_READ: state_nx = WR;
						OP_WRITE: state_nx = WW;
						default: state_nx = STOP;	// OP_HALT
					endcase
				end
			end
			WR, WW: if (advance) state_nx = P3;
			P3: if (advance) state_nx = IDLE;
			default: state_nx = state;	// STOP holds
		endcase
		if (alarm)
			state_nx = STOP;	// Dead bus ends everything
	end

	assign enter_bus = (state_nx != state) &&
		((state_nx == K1) || (state_nx == WR) || (state_nx == WW));

	// Memory cycle for the state being entered
	always_comb begin
		case (state_nx)
			WR: bus_cmd_nx = '{wr: 1'b0, addr: cmd.arg, data: 16'h0000};
			WW: bus_cmd_nx = '{wr: 1'b1, addr: cmd.arg, data: dreg};
			default: bus_cmd_nx = '{wr: 1'b0, addr: cmd.pc, data: 16'h0000};	// K1 fetch
		endcase
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state <= IDLE;
			bus_start <= 1'b0;
			hlt <= 1'b0;
			dreg <= '0;
		end else begin
			state <= state_nx;
			if (alarm)
				bus_start <= 1'b0;
			else if (enter_bus)
				bus_start <= 1'b1;	// Same edge as the state change
			else if (bus_done)
				bus_start <= 1'b0;
			if (bus_done && (state == WR))
				dreg <= rd_data;	// K1 fetch data is dropped
			if ((state == K1) && (state_nx == STOP) && (cmd.op == OP_HALT))
				hlt <= 1'b1;
		end
	end

	always_ff @(posedge got) begin
		if (enter_bus)
			bus_cmd <= bus_cmd_nx;
	end

	// Receiver stays full for the whole instruction
	assign cmd_take = (state == P3) && advance;

endmodule

`default_nettype wire

// File: hw/px_strobe_timer.sv
// P-X strob1 and strob2 timer
`default_nettype none
`timescale 1ns/10ps

module px_strobe_timer import px_state_pkg::*; (
	input  wire       got,
	input  wire       clo_,
	input  wire       px_state_t state,
	input  wire       hold,	// Bus cycle still open
	output logic      strob1,
	output logic      strob2,
	output logic      advance	// One cycle, ends the state
);

	typedef enum logic [1:0] {
		PH_S1   = 2'd0,	// strob1 running
		PH_WAIT = 2'd1,	// Between strobes, waits for the bus
		PH_S2   = 2'd2,	// strob2 running
		PH_ADV  = 2'd3	// State-advance cycle
	} phase_t;

	phase_t ph;
	logic [STROB_CNT_W-1:0] cnt;	// Cycles spent in the phase
	logic [STROB_CNT_W-1:0] s1_len;	// strob1 length of this state
	logic active;

	assign active = (state != IDLE) && (state != STOP);

	// Fetch and execute get the long strob1
	always_comb begin
		case (state)
			WR, WW: s1_len = STROB_CNT_W'(STROB1_SHORT);
			default: s1_len = STROB_CNT_W'(STROB1_LONG);
		endcase
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			ph <= PH_S1;
			cnt <= '0;
		end else if (!active) begin
			ph <= PH_S1;	// Armed for the first cycle of the next state
			cnt <= '0;
		end else begin
			case (ph)
				PH_S1: begin
					if (cnt == s1_len - 1'b1) begin
						cnt <= '0;
						ph <= hold ? PH_WAIT : PH_S2;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				PH_WAIT: if (!hold) ph <= PH_S2;	// Bus done, go on
				PH_S2: begin
					if (cnt == STROB_CNT_W'(STROB2_TICKS - 1)) begin
						cnt <= '0;
						ph <= PH_ADV;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: ph <= PH_S1;	// Sequencer moves on here
			endcase
		end
	end

	assign strob1 = active && (ph == PH_S1);
	assign strob2 = active && (ph == PH_S2);
	assign advance = active && (ph == PH_ADV);

endmodule

`default_nettype wire

// File: hw/px_top.sv
// P-X state control unit
`default_nettype none
`timescale 1ns/10ps

module px_top import px_state_pkg::*, px_bus_pkg::*; (
	input  wire         got,
	input  wire         clo_,
	input  wire         cmd_req,
	input  wire         px_cmd_t cmd,
	output logic        cmd_ack,
	output logic        bus_req,
	output px_bus_cmd_t bus_cmd,
	input  wire         bus_ack,
	input  wire         px_bus_rep_t bus_rep,
	output px_state_t   state,
	output logic        strob1,
	output logic        strob2,
	output logic        alarm,
	output logic        hlt
);

	px_cmd_t cmd_item;	// Instruction in progress
	logic cmd_valid;
	logic cmd_take;
	logic advance;
	logic bus_start;	// Also holds the timer
	px_bus_cmd_t seq_bus_cmd;
	logic bus_done;
	px_bus_rep_t rep_item;	// Last bus reply
	logic rep_valid;
	logic rep_take;

	px_hs_rx #(.payload_t(px_cmd_t)) CMD_RX (
		.got(got),
		.clo_(clo_),
		.req(cmd_req),
		.ack(cmd_ack),
		.data(cmd),
		.item(cmd_item),
		.item_valid(cmd_valid),
		.take(cmd_take)
	);

	px_strobe_timer TIMER (
		.got(got),
		.clo_(clo_),
		.state(state),
		.hold(bus_start),
		.strob1(strob1),
		.strob2(strob2),
		.advance(advance)
	);

	px_state_seq SEQ (
		.got(got),
		.clo_(clo_),
		.cmd(cmd_item),
		.cmd_valid(cmd_valid),
		.cmd_take(cmd_take),
		.advance(advance),
		.bus_done(bus_done),
		.rd_data(rep_item.data),
		.alarm(alarm),
		.bus_start(bus_start),
		.bus_cmd(seq_bus_cmd),
		.state(state),
		.hlt(hlt)
	);

	px_bus_master BUS (
		.got(got),
		.clo_(clo_),
		.start(bus_start),
		.cmd(seq_bus_cmd),
		.bus_req(bus_req),
		.bus_cmd(bus_cmd),
		.bus_ack(bus_ack),
		.rep_valid(rep_valid),
		.rep_take(rep_take),
		.done(bus_done),
		.alarm(alarm)
	);

	// Bus side drops ack by watching its own req
	px_hs_rx #(.payload_t(px_bus_rep_t)) REP_RX (
		.got(got),
		.clo_(clo_),
		.req(bus_ack),
		.ack(),
		.data(bus_rep),
		.item(rep_item),
		.item_valid(rep_valid),
		.take(rep_take)
	);

endmodule

`default_nettype wire

// File: project.f
hw/px_state_pkg.sv
hw/px_bus_pkg.sv
hw/px_hs_rx.sv
hw/px_strobe_timer.sv
hw/px_state_seq.sv
hw/px_bus_master.sv
hw/px_top.sv
tests/tb_clock.sv
tests/px_bus_model.sv
tests/px_tb.sv

// File: run.sh
#!/bin/bash
# Build the P-X testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module px_tb -f project.f -o px_sim &&
./obj_dir/px_sim ||
{ echo "simulation failed"; exit 1; }

// File: tests/px_bus_model.sv
// P-X bus responder model
`default_nettype none
`timescale 1ns/10ps

module px_bus_model import px_bus_pkg::*; (
	input  wire         got,
	input  wire         clo_,
	input  wire         bus_req,
	input  wire         px_bus_cmd_t bus_cmd,
	output logic        bus_ack,
	output px_bus_rep_t bus_rep,
	input  wire  [2:0]  delay,	// Wait cycles before ack
	input  wire         no_answer	// Never acknowledge
);

	logic [15:0] mem [logic [15:0]];	// Written words only
	logic [2:0] cnt;

	// Unwritten memory reads back a pattern of the full address
	function automatic logic [15:0] fill(input logic [15:0] a);
		return (a * 16'h0b5d) ^ {a[7:0], a[15:8]};
	endfunction

	always @(posedge got or negedge clo_) begin
		if (!clo_) begin
			bus_ack <= 1'b0;
			bus_rep <= '0;
			cnt <= '0;
		end else if (bus_req && !bus_ack && !no_answer) begin
			if (cnt >= delay) begin
				bus_ack <= 1'b1;	// Phase 2
				cnt <= '0;
				if (bus_cmd.wr)
					mem[bus_cmd.addr] = bus_cmd.data;
				else if (mem.exists(bus_cmd.addr))
					bus_rep.data <= mem[bus_cmd.addr];
				else
					bus_rep.data <= fill(bus_cmd.addr);
			end else begin
				cnt <= cnt + 3'd1;	// Slow bus
			end
		end else if (bus_ack && !bus_req) begin
			bus_ack <= 1'b0;	// Phase 4
		end
	end

endmodule

`default_nettype wire

// File: tests/px_tb.sv
// P-X control unit testbench
`default_nettype none
`timescale 1ns/10ps

module px_tb import px_state_pkg::*, px_bus_pkg::*;;

	logic got;
	logic clo_;
	logic rerun;
	logic cmd_req;
	px_cmd_t cmd;
	logic cmd_ack;
	logic bus_req;
	px_bus_cmd_t bus_cmd;
	logic bus_ack;
	px_bus_rep_t bus_rep;
	px_state_t state;
	logic strob1;
	logic strob2;
	logic alarm;
	logic hlt;
	logic [2:0] bus_delay;
	logic no_answer;

	integer seed = 32'h6b01031d;
	px_bus_cmd_t exp_bus[$];	// Bus commands still to come
	px_state_t state_log[$];	// State changes seen
	px_state_t prev_state = IDLE;
	px_bus_cmd_t held_cmd;
	logic req_d = 1'b0;
	logic ack_d = 1'b0;
	logic ack_rose = 1'b0;
	int s1_cnt = 0;
	int s2_cnt = 0;
	px_state_t s1_state;
	logic [15:0] last_read = '0;	// dreg as the unit should hold it

	tb_clock CLK (.got(got), .clo_(clo_), .rerun(rerun));

	px_bus_model MODEL (
		.got(got), .clo_(clo_), .bus_req(bus_req), .bus_cmd(bus_cmd),
		.bus_ack(bus_ack), .bus_rep(bus_rep), .delay(bus_delay), .no_answer(no_answer)
	);

	px_top UUT (
		.got(got), .clo_(clo_), .cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack),
		.bus_req(bus_req), .bus_cmd(bus_cmd), .bus_ack(bus_ack), .bus_rep(bus_rep),
		.state(state), .strob1(strob1), .strob2(strob2), .alarm(alarm), .hlt(hlt)
	);

	task automatic die(input string msg);
		$display("%s at %0t", msg, $time);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [33:0] exp, input logic [33:0] act);
		assert (act === exp) else begin
			$display("Error at %0t: %s expected %h actual %h", $time, name, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	endtask

	function automatic logic [15:0] fill(input logic [15:0] a);
		return (a * 16'h0b5d) ^ {a[7:0], a[15:8]};	// Same pattern as the model
	endfunction

	function automatic int s1_len(input px_state_t s);
		return (s == WR || s == WW) ? STROB1_SHORT : STROB1_LONG;
	endfunction

	// Protocol monitors, sampled away from the driving edge
	always @(negedge got) begin
		if (clo_) begin
			if (state !== prev_state) begin
				state_log.push_back(state);
				prev_state = state;
			end
			if (ack_rose)
				check("state", 34'(K1), 34'(state));	// One cycle after cmd_ack
			ack_rose = cmd_ack && !ack_d;
			if (ack_rose)
				check("state", 34'(IDLE), 34'(state));	// No ack mid-instruction
			ack_d = cmd_ack;
			if (bus_req && !req_d) begin
				assert (!bus_ack) else die("bus_req rose with bus_ack still high");
				if (exp_bus.size() == 0)
					die("Unexpected bus command");
				check("bus_cmd", 34'(exp_bus.pop_front()), 34'(bus_cmd));
				held_cmd = bus_cmd;
			end else if (bus_req) begin
				check("bus_cmd", 34'(held_cmd), 34'(bus_cmd));	// Stable during req
			end
			req_d = bus_req;
			assert (!(strob1 && strob2)) else die("strob1 and strob2 overlap");
			if (strob1) begin
				s1_cnt++;
				s1_state = state;
			end else if (s1_cnt != 0) begin
				check("strob1 length", 34'(s1_len(s1_state)), 34'(s1_cnt));
				s1_cnt = 0;
			end
			if (strob2) begin
				s2_cnt++;
			end else if (s2_cnt != 0) begin
				check("strob2 length", 34'(STROB2_TICKS), 34'(s2_cnt));
				s2_cnt = 0;
			end
		end else begin
			prev_state = IDLE;
			req_d = 1'b0;
			ack_d = 1'b0;
			ack_rose = 1'b0;
			s1_cnt = 0;
			s2_cnt = 0;
		end
	end

	task automatic wait_ack(input logic level);
		int t;
		t = 0;
		@(negedge got);
		while (cmd_ack !== level) begin
			if (t == 200)
				die("cmd_ack never changed");
			t++;
			@(negedge got);
		end
	endtask

	task automatic wait_state(input px_state_t s);
		int t;
		t = 0;
		while (state !== s) begin
			if (t == 1000)
				die("State never reached");
			t++;
			@(negedge got);
		end
	endtask

	task automatic wait_reset;
		int t;
		t = 0;
		@(negedge got);
		while (!clo_) begin
			if (t == 50)
				die("Reset never released");
			t++;
			@(negedge got);
		end
	endtask

	task automatic send_cmd(input px_cmd_t c);
		@(posedge got);
		cmd <= c;
		cmd_req <= 1'b1;	// Phase 1
		wait_ack(1'b1);
		@(posedge got);
		cmd_req <= 1'b0;	// Phase 3
		wait_ack(1'b0);
	endtask

	task automatic check_idle_outputs;
		check("state", 34'(IDLE), 34'(state));
		check("cmd_ack", 34'(0), 34'(cmd_ack));
		check("bus_req", 34'(0), 34'(bus_req));
		check("strob1", 34'(0), 34'(strob1));
		check("strob2", 34'(0), 34'(strob2));
		check("alarm", 34'(0), 34'(alarm));
		check("hlt", 34'(0), 34'(hlt));
	endtask

	task automatic run_instr(input px_op_t op);
		px_cmd_t c;
		px_state_t path[$];
		c.op = op;
		c.pc = 16'($random(seed));
		c.arg = 16'($random(seed));
		if (op == OP_READ)
			c.arg[15] = 1'b0;	// Reads stay below the written half
		if (op == OP_WRITE)
			c.arg[15] = 1'b1;
		exp_bus.push_back('{wr: 1'b0, addr: c.pc, data: 16'h0000});	// Fetch
		path.push_back(K1);
		case (op)
			OP_READ: begin
				exp_bus.push_back('{wr: 1'b0, addr: c.arg, data: 16'h0000});
				last_read = fill(c.arg);
				path.push_back(WR);
			end
			OP_WRITE: begin
				exp_bus.push_back('{wr: 1'b1, addr: c.arg, data: last_read});
				path.push_back(WW);
			end
			default: ;
		endcase
		path.push_back(op == OP_HALT ? STOP : P3);
		if (op != OP_HALT)
			path.push_back(IDLE);
		@(posedge got);
		bus_delay <= 3'({$random(seed)} % 6);
		state_log.delete();
		send_cmd(c);
		wait_state(path[path.size()-1]);
		@(negedge got);
		check("path length", 34'(path.size()), 34'(state_log.size()));
		foreach (path[i])
			check("state", 34'(path[i]), 34'(state_log[i]));
		check("pending bus commands", 34'(0), 34'(exp_bus.size()));
	endtask

	// Second request raised while the first instruction still runs
	task automatic run_back_to_back;
		px_cmd_t a;
		px_cmd_t b;
		a.op = OP_REG;
		a.pc = 16'($random(seed));
		a.arg = 16'($random(seed));
		b = a;
		b.pc = 16'($random(seed));
		exp_bus.push_back('{wr: 1'b0, addr: a.pc, data: 16'h0000});
		exp_bus.push_back('{wr: 1'b0, addr: b.pc, data: 16'h0000});
		@(posedge got);
		bus_delay <= 3'({$random(seed)} % 6);
		state_log.delete();
		send_cmd(a);
		send_cmd(b);	// Held off until the first one is back in IDLE
		wait_state(IDLE);
		@(negedge got);
		check("path length", 34'(6), 34'(state_log.size()));
		check("pending bus commands", 34'(0), 34'(exp_bus.size()));
	endtask

	initial begin
		int n;
		rerun <= 1'b0;
		cmd_req <= 1'b0;
		cmd <= '0;
		bus_delay <= 3'd0;
		no_answer <= 1'b0;
		wait_reset();
		check_idle_outputs();
		for (int i = 0; i < 24; i++)
			run_instr(px_op_t'({$random(seed)} % 3));
		for (int i = 0; i < 3; i++)
			run_back_to_back();
		run_instr(OP_HALT);
		check("hlt", 34'(1), 34'(hlt));
		@(posedge got);
		cmd_req <= 1'b1;	// Must be ignored once halted
		repeat (30) begin
			@(negedge got);
			check("cmd_ack", 34'(0), 34'(cmd_ack));
		end
		@(posedge got);
		cmd_req <= 1'b0;
		rerun <= 1'b1;
		wait_reset();
		check_idle_outputs();
		@(posedge got);
		no_answer <= 1'b1;	// Dead bus
		exp_bus.delete();
		exp_bus.push_back('{wr: 1'b0, addr: 16'h1234, data: 16'h0000});
		send_cmd('{op: OP_REG, pc: 16'h1234, arg: 16'h0042});
		n = 0;
		while (!bus_req) begin
			if (n == 100)
				die("bus_req never rose");
			n++;
			@(negedge got);
		end
		n = 0;
		while (!alarm) begin
			if (n == 2 * BUS_TIMEOUT)
				die("Alarm never rose");
			n++;
			@(negedge got);
		end
		check("alarm delay", 34'(BUS_TIMEOUT), 34'(n));
		check("bus_req", 34'(0), 34'(bus_req));
		wait_state(STOP);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// Testbench clock and reset
`default_nettype none
`timescale 1ns/10ps

module tb_clock (
	output logic got,
	output logic clo_,
	input  wire  rerun	// Rising edge restarts the reset
);

	initial begin
		got = 1'b0;
		forever #5 got = ~got;	// 10 ns period
	end

	initial begin
		clo_ <= 1'b0;
		repeat (10) @(posedge got);
		clo_ <= 1'b1;
		forever begin
			@(posedge rerun);
			clo_ <= 1'b0;	// Second reset, same length
			repeat (10) @(posedge got);
			clo_ <= 1'b1;
		end
	end

endmodule

`default_nettype wire
